//--- logic/arith_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Add/sub/MAC/clear datapath with one accumulator and a shared adder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module arith_unit (
    input  logic                             i_clk,
    input  logic                             i_rstn,
    input  logic                             i_issue,
    input  logic [mac_cfg_pkg::DATA_W-1:0]   i_a,
    input  logic [mac_cfg_pkg::DATA_W-1:0]   i_b,
    input  mac_ops_pkg::op_e                 i_op,
    input  logic                             i_sender_free,
    output logic                             o_unit_ready,
    output logic                             o_done,
    output logic [mac_cfg_pkg::DATA_W-1:0]   o_res
);

    mac_ops_pkg::arith_state_e state;
    mac_ops_pkg::op_e op_q;

    logic [mac_cfg_pkg::DATA_W-1:0] a_q;
    logic [mac_cfg_pkg::DATA_W-1:0] b_q;
    logic [mac_cfg_pkg::DATA_W-1:0] prod_q;
    logic [mac_cfg_pkg::DATA_W-1:0] acc;
    logic [mac_cfg_pkg::DATA_W-1:0] adder_a;
    logic [mac_cfg_pkg::DATA_W-1:0] adder_b;
    logic [mac_cfg_pkg::DATA_W-1:0] sum;

    // Operand select for the single adder
    always_comb begin
        case (op_q)
            mac_ops_pkg::OP_ADD: begin
                adder_a = a_q;
                adder_b = b_q;
            end
            mac_ops_pkg::OP_SUB: begin
                adder_a = a_q;
                adder_b = ~b_q + 1'b1;  // Two's complement
            end
            mac_ops_pkg::OP_MAC: begin
                adder_a = prod_q;
                adder_b = acc;
            end
            default: begin  // CLR
                adder_a = '0;
                adder_b = '0;
            end
        endcase
    end

    assign sum = adder_a + adder_b;  // Wraps modulo 2^DATA_W

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state <= mac_ops_pkg::ARITH_IDLE;
            acc   <= '0;
        end else begin
            case (state)
                mac_ops_pkg::ARITH_IDLE: begin
                    if (i_issue) begin
                        if (i_op == mac_ops_pkg::OP_MAC) begin
                            state <= mac_ops_pkg::ARITH_MUL;
                        end else begin
                            state <= mac_ops_pkg::ARITH_WRITE;
                        end
                    end
                end
                mac_ops_pkg::ARITH_MUL: state <= mac_ops_pkg::ARITH_WRITE;
                mac_ops_pkg::ARITH_WRITE: begin
                    acc   <= sum;  // Accumulator always tracks the last result
                    state <= mac_ops_pkg::ARITH_IDLE;
                end
                default: state <= mac_ops_pkg::ARITH_IDLE;
            endcase
        end
    end

    // Operands and product
    always_ff @(posedge i_clk) begin
        if (state == mac_ops_pkg::ARITH_IDLE && i_issue) begin
            a_q  <= i_a;
            b_q  <= i_b;
            op_q <= i_op;
        end
        if (state == mac_ops_pkg::ARITH_MUL) begin
            prod_q <= a_q * b_q;  // Low DATA_W bits kept
        end
    end

    assign o_done       = (state == mac_ops_pkg::ARITH_WRITE);
    assign o_res        = sum;
    assign o_unit_ready = (state == mac_ops_pkg::ARITH_IDLE) && i_sender_free;

endmodule : arith_unit

//--- logic/cmd_intake.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase command receiver, issues one command per handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cmd_intake (
    input  logic                             i_clk,
    input  logic                             i_rstn,
    input  logic                             i_cmd_req,
    input  logic [mac_cfg_pkg::DATA_W-1:0]   i_cmd_a,
    input  logic [mac_cfg_pkg::DATA_W-1:0]   i_cmd_b,
    input  mac_ops_pkg::op_e                 i_cmd_op,
    output logic                             o_cmd_ack,
    input  logic                             i_unit_ready,
    output logic                             o_issue,
    output logic [mac_cfg_pkg::DATA_W-1:0]   o_issue_a,
    output logic [mac_cfg_pkg::DATA_W-1:0]   o_issue_b,
    output mac_ops_pkg::op_e                 o_issue_op
);

    mac_ops_pkg::intake_state_e state;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state     <= mac_ops_pkg::INTK_IDLE;
            o_cmd_ack <= 1'b0;
            o_issue   <= 1'b0;
        end else begin
            o_issue <= 1'b0;  // Single-cycle pulse
            case (state)
                mac_ops_pkg::INTK_IDLE: begin
                    if (i_cmd_req) begin
                        if (i_unit_ready) begin
                            o_issue   <= 1'b1;
                            o_cmd_ack <= 1'b1;
                            state     <= mac_ops_pkg::INTK_WAIT_DROP;
                        end else begin
                            state <= mac_ops_pkg::INTK_HOLD;  // Back-pressure, no ack yet
                        end
                    end
                end
                mac_ops_pkg::INTK_HOLD: begin
                    if (i_unit_ready) begin
                        o_issue   <= 1'b1;
                        o_cmd_ack <= 1'b1;
                        state     <= mac_ops_pkg::INTK_WAIT_DROP;
                    end
                end
                mac_ops_pkg::INTK_WAIT_DROP: begin
                    // Release ack once the host has let go of req
                    if (!i_cmd_req) begin
                        o_cmd_ack <= 1'b0;
                        state     <= mac_ops_pkg::INTK_IDLE;
                    end
                end
                default: state <= mac_ops_pkg::INTK_IDLE;
            endcase
        end
    end

    // Command copy, host data is free to change after ack
    always_ff @(posedge i_clk) begin
        if (state == mac_ops_pkg::INTK_IDLE && i_cmd_req) begin
            o_issue_a  <= i_cmd_a;
            o_issue_b  <= i_cmd_b;
            o_issue_op <= i_cmd_op;
        end
    end

endmodule : cmd_intake

//--- logic/mac_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath sizing for the MAC engine, referenced by scoped name only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mac_cfg_pkg;

    // Operands, accumulator and result share one width
    localparam int DATA_W = 32;

    localparam int OP_W = 2;  // Opcode field

endpackage : mac_cfg_pkg

//--- logic/mac_engine_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAC engine top level, command port in and result port out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mac_engine_top (
    input  logic                             i_clk,
    input  logic                             i_rstn,
    input  logic                             i_cmd_req,
    input  logic [mac_cfg_pkg::DATA_W-1:0]   i_cmd_a,
    input  logic [mac_cfg_pkg::DATA_W-1:0]   i_cmd_b,
    input  mac_ops_pkg::op_e                 i_cmd_op,
    output logic                             o_cmd_ack,
    output logic                             o_res_req,
    output logic [mac_cfg_pkg::DATA_W-1:0]   o_res,
    input  logic                             i_res_ack
);

    logic                           issue;
    logic [mac_cfg_pkg::DATA_W-1:0] issue_a;
    logic [mac_cfg_pkg::DATA_W-1:0] issue_b;
    mac_ops_pkg::op_e               issue_op;
    logic                           unit_ready;  // Includes sender_free
    logic                           done;
    logic [mac_cfg_pkg::DATA_W-1:0] done_res;
    logic                           sender_free;

    cmd_intake intake_i (
        .i_clk(i_clk), .i_rstn(i_rstn),
        .i_cmd_req(i_cmd_req), .i_cmd_a(i_cmd_a), .i_cmd_b(i_cmd_b),
        .i_cmd_op(i_cmd_op), .o_cmd_ack(o_cmd_ack),
        .i_unit_ready(unit_ready), .o_issue(issue),
        .o_issue_a(issue_a), .o_issue_b(issue_b), .o_issue_op(issue_op)
    );

    arith_unit arith_i (
        .i_clk(i_clk), .i_rstn(i_rstn),
        .i_issue(issue), .i_a(issue_a), .i_b(issue_b), .i_op(issue_op),
        .i_sender_free(sender_free), .o_unit_ready(unit_ready),
        .o_done(done), .o_res(done_res)
    );

    result_sender sender_i (
        .i_clk(i_clk), .i_rstn(i_rstn),
        .i_done(done), .i_res(done_res), .o_sender_free(sender_free),
        .o_res_req(o_res_req), .o_res(o_res), .i_res_ack(i_res_ack)
    );

endmodule : mac_engine_top

//--- logic/mac_ops_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode and FSM state encodings shared by the MAC engine blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mac_ops_pkg;

    typedef enum logic [mac_cfg_pkg::OP_W-1:0] {
        OP_ADD = 2'd0,  // a + b
        OP_SUB = 2'd1,  // a - b
        OP_MAC = 2'd2,  // acc + a * b
        OP_CLR = 2'd3   // Result zero
    } op_e;

    // Command receiver
    typedef enum logic [1:0] {INTK_IDLE, INTK_HOLD, INTK_WAIT_DROP} intake_state_e;

    // Datapath sequencing
    typedef enum logic [1:0] {ARITH_IDLE, ARITH_MUL, ARITH_WRITE} arith_state_e;

    // Result sender
    typedef enum logic [1:0] {SEND_IDLE, SEND_REQ, SEND_WAIT_DROP} send_state_e;

endpackage : mac_ops_pkg

//--- logic/result_sender.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase result sender, holds each result until the host acks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module result_sender (
    input  logic                             i_clk,
    input  logic                             i_rstn,
    input  logic                             i_done,
    input  logic [mac_cfg_pkg::DATA_W-1:0]   i_res,
    output logic                             o_sender_free,
    output logic                             o_res_req,
    output logic [mac_cfg_pkg::DATA_W-1:0]   o_res,
    input  logic                             i_res_ack
);

    mac_ops_pkg::send_state_e state;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state <= mac_ops_pkg::SEND_IDLE;
        end else begin
            case (state)
                mac_ops_pkg::SEND_IDLE: begin
                    if (i_done) state <= mac_ops_pkg::SEND_REQ;
                end
                mac_ops_pkg::SEND_REQ: begin
                    if (i_res_ack) state <= mac_ops_pkg::SEND_WAIT_DROP;
                end
                mac_ops_pkg::SEND_WAIT_DROP: begin
                    // Free only once the host has dropped ack
                    if (!i_res_ack) state <= mac_ops_pkg::SEND_IDLE;
                end
                default: state <= mac_ops_pkg::SEND_IDLE;
            endcase
        end
    end

    // Result held stable for the whole request phase
    always_ff @(posedge i_clk) begin
        if (state == mac_ops_pkg::SEND_IDLE && i_done) begin
            o_res <= i_res;
        end
    end

    assign o_res_req     = (state == mac_ops_pkg::SEND_REQ);
    assign o_sender_free = (state == mac_ops_pkg::SEND_IDLE);

endmodule : result_sender

//--- mac_engine.f
logic/mac_cfg_pkg.sv
logic/mac_ops_pkg.sv
logic/cmd_intake.sv
logic/arith_unit.sv
logic/result_sender.sv
logic/mac_engine_top.sv
verification/mac_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the MAC engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mac_engine_tb \
    -f mac_engine.f -o mac_engine_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mac_engine_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/mac_engine_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the MAC engine, built and run by run_sim.sh
// Directed opcode cases first, then random traffic with slow result acks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mac_engine_tb;

    localparam int DW             = mac_cfg_pkg::DATA_W;
    localparam int N_DIRECTED     = 10;
    localparam int N_RANDOM       = 60;
    localparam int N_CMDS         = N_DIRECTED + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_CMDS * 40 + 200;

    logic             i_clk;
    logic             i_rstn;
    logic             i_cmd_req;
    logic [DW-1:0]    i_cmd_a;
    logic [DW-1:0]    i_cmd_b;
    mac_ops_pkg::op_e i_cmd_op;
    logic             o_cmd_ack;
    logic             o_res_req;
    logic [DW-1:0]    o_res;
    logic             i_res_ack;

    integer seed         = 32'ha01a_8325;
    int     errors       = 0;
    int     accepted     = 0;  // Commands acked by the DUT
    int     completed    = 0;  // Results taken by the responder
    int     since_accept = 0;
    int     exp_lat      = 0;
    bit     cmd_started  = 1'b0;
    bit     slow_ack     = 1'b0;
    bit     pend_mac     = 1'b0;  // Opcode of the command still waiting for ack
    bit     ack_d        = 1'b0;

    logic [DW-1:0] model_acc = '0;
    logic [DW-1:0] exp_q[$];
    logic [DW-1:0] exp_head  = '0;
    int            exp_count = 0;

    mac_engine_top dut_i (
        .i_clk(i_clk), .i_rstn(i_rstn),
        .i_cmd_req(i_cmd_req), .i_cmd_a(i_cmd_a), .i_cmd_b(i_cmd_b),
        .i_cmd_op(i_cmd_op), .o_cmd_ack(o_cmd_ack),
        .o_res_req(o_res_req), .o_res(o_res), .i_res_ack(i_res_ack)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [DW-1:0] expected_result(input mac_ops_pkg::op_e op,
                                                      input logic [DW-1:0] a,
                                                      input logic [DW-1:0] b,
                                                      input logic [DW-1:0] acc);
        case (op)
            mac_ops_pkg::OP_ADD: return a + b;
            mac_ops_pkg::OP_SUB: return a - b;
            mac_ops_pkg::OP_MAC: return acc + a * b;  // Truncated to DW bits
            default:             return '0;
        endcase
    endfunction

    task automatic record_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic refresh_head();
        exp_count = exp_q.size();
        if (exp_count > 0) exp_head = exp_q[0];
    endtask

    // Host side of the command handshake, the model is updated in command order
    task automatic send_command(input mac_ops_pkg::op_e op, input logic [DW-1:0] a,
                                input logic [DW-1:0] b);
        logic [DW-1:0] res;
        int            hold;
        res       = expected_result(op, a, b, model_acc);
        model_acc = res;
        exp_q.push_back(res);
        refresh_head();
        @(negedge i_clk);
        i_cmd_a     = a;
        i_cmd_b     = b;
        i_cmd_op    = op;
        pend_mac    = (op == mac_ops_pkg::OP_MAC);
        i_cmd_req   = 1'b1;
        cmd_started = 1'b1;
        do begin
            @(negedge i_clk);
        end while (!o_cmd_ack);
        hold = $unsigned($random(seed)) % 3;  // Host may keep req up a while after ack
        repeat (hold) @(negedge i_clk);
        i_cmd_req = 1'b0;
        i_cmd_a   = $random(seed);  // Operands are free once acked
        i_cmd_b   = $random(seed);
        while (o_cmd_ack) @(negedge i_clk);
    endtask

    // Acceptance tracking for latency and back-pressure checks
    always @(posedge i_clk) begin
        ack_d <= o_cmd_ack;
        if (o_cmd_ack && !ack_d) begin
            accepted     <= accepted + 1;
            since_accept <= 1;
            exp_lat      <= pend_mac ? 3 : 2;
        end else begin
            since_accept <= since_accept + 1;
        end
    end

    initial begin : result_acker
        int wait_cycles;
        int drop_wait;
        forever begin
            @(negedge i_clk);
            if (o_res_req) begin
                wait_cycles = $unsigned($random(seed)) % 8;
                if (slow_ack) wait_cycles = 4 + wait_cycles % 4;
                repeat (wait_cycles) @(negedge i_clk);
                i_res_ack = 1'b1;
                while (o_res_req) @(negedge i_clk);
                if (exp_q.size() > 0) void'(exp_q.pop_front());
                refresh_head();
                completed++;
                drop_wait = $unsigned($random(seed)) % 3;  // Ack may linger after req drops
                repeat (drop_wait) @(negedge i_clk);
                i_res_ack = 1'b0;
            end
        end
    end

    quiet_before_cmd: assert property (@(posedge i_clk) !cmd_started |-> !o_cmd_ack && !o_res_req)
        else record_error("A port handshake was active before the first command");
    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $rose(o_cmd_ack) |-> $past(i_cmd_req))
        else record_error("o_cmd_ack rose without i_cmd_req high");
    ack_held_with_req: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $fell(o_cmd_ack) |-> !$past(i_cmd_req))
        else record_error("o_cmd_ack fell while i_cmd_req was still high");
    no_ack_while_pending: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $rose(o_cmd_ack) |-> accepted == completed)
        else record_error("A command was acked while an earlier result was still pending");
    res_req_held: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $past(o_res_req) && !$past(i_res_ack) |-> o_res_req)
        else record_error("o_res_req dropped before i_res_ack");
    res_held: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $past(o_res_req) && !$past(i_res_ack) |-> o_res == $past(o_res))
        else record_error($sformatf("ERROR o_res changed from %h to %h before ack",
                                    $past(o_res), $sampled(o_res)));
    req_after_ack_low: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $rose(o_res_req) |-> !$past(i_res_ack))
        else record_error("o_res_req rose while i_res_ack was still high");
    res_latency: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $rose(o_res_req) |-> since_accept == exp_lat)
        else record_error($sformatf("ERROR o_res_req latency expected %h got %h",
                                    exp_lat, $sampled(since_accept)));
    res_expected: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_res_req |-> exp_count > 0)
        else record_error("A result arrived with no command outstanding");
    res_value: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_res_req && exp_count > 0 |-> o_res == exp_head)
        else record_error($sformatf("ERROR o_res expected %h got %h",
                                    exp_head, $sampled(o_res)));

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge i_clk);
        $display("Timeout: results still missing after %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main_sequence
        logic [DW-1:0] r_a;
        logic [DW-1:0] r_b;
        logic [DW-1:0] r_op;
        int            gap;
        i_rstn    = 1'b0;
        i_cmd_req = 1'b0;
        i_cmd_a   = '0;
        i_cmd_b   = '0;
        i_cmd_op  = mac_ops_pkg::OP_ADD;
        i_res_ack = 1'b0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rstn = 1'b1;
        repeat (3) @(negedge i_clk);

        send_command(mac_ops_pkg::OP_ADD, 32'hffff_ffff, 32'h0000_0002);  // Wraps to 1
        send_command(mac_ops_pkg::OP_ADD, 32'h1234_5678, 32'h8765_4321);
        send_command(mac_ops_pkg::OP_SUB, 32'h0000_0001, 32'h0000_0003);  // Borrow past zero
        send_command(mac_ops_pkg::OP_SUB, 32'h9000_0000, 32'h1000_0001);
        send_command(mac_ops_pkg::OP_MAC, 32'h0000_0003, 32'h0000_0005);
        send_command(mac_ops_pkg::OP_CLR, 32'h5a5a_1234, 32'h0f0f_7777);
        // First MAC after a clear is the bare product
        send_command(mac_ops_pkg::OP_MAC, 32'h0000_0007, 32'h0000_0009);
        send_command(mac_ops_pkg::OP_MAC, 32'hffff_ffff, 32'h0000_0002);
        send_command(mac_ops_pkg::OP_MAC, 32'h0001_0000, 32'h0001_0000);  // Product wraps
        send_command(mac_ops_pkg::OP_CLR, 32'h0000_0000, 32'h0000_0000);

        for (int i = 0; i < N_RANDOM; i++) begin
            if (i == N_RANDOM / 2) slow_ack = 1'b1;  // Long result waits from here on
            r_op = $random(seed);
            r_a  = $random(seed);
            r_b  = $random(seed);
            send_command(mac_ops_pkg::op_e'(r_op[1:0]), r_a, r_b);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge i_clk);
        end

        while (completed < N_CMDS) @(negedge i_clk);
        repeat (10) @(negedge i_clk);
        assert (accepted == N_CMDS && completed == N_CMDS && exp_q.size() == 0)
            else record_error($sformatf(
                "Command and result counts differ: %0d accepted, %0d returned",
                accepted, completed));

        $display("Finished: %0d commands, %0d results, %0d errors", N_CMDS, completed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : mac_engine_tb
